//--- cache_axi_pkg.sv
package cache_axi_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] word_t;    // one AXI beat
    typedef logic [3:0]  axi_len_t; // beats minus one, so 16 words max per line

    // line refill FSM
    typedef enum logic [1:0] {
        rf_idle,
        rf_addr,
        rf_data,
        rf_ret
    } refill_state_t;

    // dirty line writeback FSM
    typedef enum logic [1:0] {
        wb_idle,
        wb_addr,
        wb_data,
        wb_resp
    } wb_state_t;

endpackage

//--- axi_rd_if.sv
interface axi_rd_if
    import cache_axi_pkg::*;
();
    // address channel
    addr_t    araddr;
    axi_len_t arlen;
    logic     arvalid;
    logic     arready;

    // read data channel
    word_t    rdata;
    logic     rlast;
    logic     rvalid;
    logic     rready;

    modport master (
        output araddr, arlen, arvalid, rready,
        input  arready, rdata, rlast, rvalid
    );

    modport slave (
        input  araddr, arlen, arvalid, rready,
        output arready, rdata, rlast, rvalid
    );

endinterface

//--- line_refill.sv
module line_refill
    import cache_axi_pkg::*;
#(
    parameter int line_words = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   rd_req,
    input  addr_t                  rd_addr,
    output logic                   ret_valid,
    output word_t [line_words-1:0] ret_line,
    axi_rd_if.master               rd
);
    localparam int cnt_w = (line_words > 1) ? $clog2(line_words) : 1;

    refill_state_t          state;
    refill_state_t          state_next;
    logic [cnt_w-1:0]       beat_cnt;
    addr_t                  addr_q;
    word_t [line_words-1:0] line_q;
    logic                   ar_fire;
    logic                   r_fire;

    assign ar_fire = rd.arvalid && rd.arready;
    assign r_fire  = rd.rvalid && rd.rready;

    always_comb begin
        state_next = state;
        unique case (state)
            rf_idle: begin
                if (rd_req) begin
                    state_next = rf_addr;
                end
            end
            rf_addr: begin
                if (ar_fire) begin
                    state_next = rf_data;
                end
            end
            rf_data: begin
                if (r_fire && rd.rlast) begin
                    state_next = rf_ret;
                end
            end
            rf_ret: begin
                state_next = rf_idle; // one cycle return strobe
            end
            default: begin
                state_next = rf_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= rf_idle;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (ar_fire) begin
                beat_cnt <= '0;
            end else if (r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == rf_idle && rd_req) begin
            addr_q <= rd_addr;
        end
        if (r_fire) begin
            line_q[beat_cnt] <= rd.rdata; // beat k lands in word k
        end
    end

    assign rd.araddr  = addr_q;
    assign rd.arlen   = axi_len_t'(line_words - 1);
    assign rd.arvalid = (state == rf_addr);
    assign rd.rready  = (state == rf_data);

    assign ret_valid = (state == rf_ret);
    assign ret_line  = line_q;

endmodule

//--- line_writeback.sv
module line_writeback
    import cache_axi_pkg::*;
#(
    parameter int line_words = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_req,
    input  addr_t                  wr_addr,
    input  word_t [line_words-1:0] wr_line,
    output logic                   wr_done,
    output addr_t                  m_axi_awaddr,
    output axi_len_t               m_axi_awlen,
    output logic                   m_axi_awvalid,
    input  logic                   m_axi_awready,
    output word_t                  m_axi_wdata,
    output logic                   m_axi_wlast,
    output logic                   m_axi_wvalid,
    input  logic                   m_axi_wready,
    input  logic                   m_axi_bvalid,
    output logic                   m_axi_bready
);
    localparam int cnt_w = (line_words > 1) ? $clog2(line_words) : 1;

    wb_state_t              state;
    wb_state_t              state_next;
    logic [cnt_w-1:0]       word_idx;
    addr_t                  addr_q;
    word_t [line_words-1:0] line_q;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   b_fire;

    assign aw_fire = m_axi_awvalid && m_axi_awready;
    assign w_fire  = m_axi_wvalid && m_axi_wready;
    assign b_fire  = m_axi_bvalid && m_axi_bready;

    always_comb begin
        state_next = state;
        unique case (state)
            wb_idle: begin
                if (wr_req) begin
                    state_next = wb_addr;
                end
            end
            wb_addr: begin
                if (aw_fire) begin
                    state_next = wb_data;
                end
            end
            wb_data: begin
                if (w_fire && m_axi_wlast) begin
                    state_next = wb_resp;
                end
            end
            wb_resp: begin
                if (b_fire) begin
                    state_next = wb_idle;
                end
            end
            default: begin
                state_next = wb_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= wb_idle;
            word_idx <= '0;
            wr_done  <= 1'b0;
        end else begin
            state   <= state_next;
            wr_done <= b_fire; // completion one cycle after the response
            if (aw_fire) begin
                word_idx <= '0;
            end else if (w_fire) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // dirty line is frozen here so the cache may reuse its copy
    always_ff @(posedge clk) begin
        if (state == wb_idle && wr_req) begin
            addr_q <= wr_addr;
            line_q <= wr_line;
        end
    end

    assign m_axi_awaddr  = addr_q;
    assign m_axi_awlen   = axi_len_t'(line_words - 1);
    assign m_axi_awvalid = (state == wb_addr);

    assign m_axi_wdata  = line_q[word_idx];
    assign m_axi_wvalid = (state == wb_data);
    assign m_axi_wlast  = (state == wb_data) && (word_idx == cnt_w'(line_words - 1));

    assign m_axi_bready = (state == wb_resp);

endmodule

//--- read_arbiter.sv
module read_arbiter
    import cache_axi_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    axi_rd_if.slave  i_rd,
    axi_rd_if.slave  d_rd,
    output addr_t    m_axi_araddr,
    output axi_len_t m_axi_arlen,
    output logic     m_axi_arvalid,
    output logic     m_axi_rready,
    input  logic     m_axi_arready,
    input  word_t    m_axi_rdata,
    input  logic     m_axi_rlast,
    input  logic     m_axi_rvalid
);
    logic busy;
    logic owner_d;  // 1 when the dcache owns the channel
    logic sel_d;
    logic last_fire;

    // fixed priority while idle, registered owner once an address is out
    assign sel_d     = busy ? owner_d : d_rd.arvalid;
    assign last_fire = m_axi_rvalid && m_axi_rready && m_axi_rlast;

    // lock as soon as an address is offered so araddr holds through arready stalls
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
        end else if (busy) begin
            if (last_fire) begin
                busy <= 1'b0;
            end
        end else if (m_axi_arvalid) begin
            busy    <= 1'b1;
            owner_d <= sel_d;
        end
    end

    assign m_axi_araddr  = sel_d ? d_rd.araddr  : i_rd.araddr;
    assign m_axi_arlen   = sel_d ? d_rd.arlen   : i_rd.arlen;
    assign m_axi_arvalid = sel_d ? d_rd.arvalid : i_rd.arvalid;
    assign m_axi_rready  = sel_d ? d_rd.rready  : i_rd.rready;

    // non-owner sees a quiet channel
    assign d_rd.arready = sel_d && m_axi_arready;
    assign d_rd.rvalid  = sel_d && m_axi_rvalid;
    assign d_rd.rlast   = sel_d && m_axi_rlast;

    assign i_rd.arready = !sel_d && m_axi_arready;
    assign i_rd.rvalid  = !sel_d && m_axi_rvalid;
    assign i_rd.rlast   = !sel_d && m_axi_rlast;

    assign d_rd.rdata = m_axi_rdata;
    assign i_rd.rdata = m_axi_rdata;

endmodule

//--- axi_cache_bridge.sv
module axi_cache_bridge
    import cache_axi_pkg::*;
#(
    parameter int icache_line_words = 8,
    parameter int dcache_line_words = 8
) (
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic                          ic_rd_req,
    input  addr_t                         ic_rd_addr,
    output logic                          ic_ret_valid,
    output word_t [icache_line_words-1:0] ic_ret_line,

    input  logic                          dc_rd_req,
    input  addr_t                         dc_rd_addr,
    output logic                          dc_ret_valid,
    output word_t [dcache_line_words-1:0] dc_ret_line,

    input  logic                          dc_wr_req,
    input  addr_t                         dc_wr_addr,
    input  word_t [dcache_line_words-1:0] dc_wr_line,
    output logic                          dc_wr_done,

    output addr_t                         m_axi_araddr,
    output axi_len_t                      m_axi_arlen,
    output logic                          m_axi_arvalid,
    input  logic                          m_axi_arready,
    input  word_t                         m_axi_rdata,
    input  logic                          m_axi_rlast,
    input  logic                          m_axi_rvalid,
    output logic                          m_axi_rready,

    output addr_t                         m_axi_awaddr,
    output axi_len_t                      m_axi_awlen,
    output logic                          m_axi_awvalid,
    input  logic                          m_axi_awready,
    output word_t                         m_axi_wdata,
    output logic                          m_axi_wlast,
    output logic                          m_axi_wvalid,
    input  logic                          m_axi_wready,
    input  logic                          m_axi_bvalid,
    output logic                          m_axi_bready
);
    axi_rd_if i_rd ();
    axi_rd_if d_rd ();

    line_refill #(
        .line_words (icache_line_words)
    ) u_icache_refill (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_req    (ic_rd_req),
        .rd_addr   (ic_rd_addr),
        .ret_valid (ic_ret_valid),
        .ret_line  (ic_ret_line),
        .rd        (i_rd.master)
    );

    line_refill #(
        .line_words (dcache_line_words)
    ) u_dcache_refill (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_req    (dc_rd_req),
        .rd_addr   (dc_rd_addr),
        .ret_valid (dc_ret_valid),
        .ret_line  (dc_ret_line),
        .rd        (d_rd.master)
    );

    // write side has a single master, no arbitration needed
    line_writeback #(
        .line_words (dcache_line_words)
    ) u_dcache_wb (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr_req        (dc_wr_req),
        .wr_addr       (dc_wr_addr),
        .wr_line       (dc_wr_line),
        .wr_done       (dc_wr_done),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awlen   (m_axi_awlen),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wlast   (m_axi_wlast),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready)
    );

    read_arbiter u_rd_arb (
        .clk           (clk),
        .arst_n        (arst_n),
        .i_rd          (i_rd.slave),
        .d_rd          (d_rd.slave),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arlen   (m_axi_arlen),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_rready  (m_axi_rready),
        .m_axi_arready (m_axi_arready),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rlast   (m_axi_rlast),
        .m_axi_rvalid  (m_axi_rvalid)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period = 8
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2) clk = ~clk;
    end

endmodule

//--- axi_cache_bridge_tb.sv
module axi_cache_bridge_tb
    import cache_axi_pkg::*;
();
    localparam int ic_lw      = 8;
    localparam int dc_lw      = 4;
    localparam int n_tests    = 8;
    localparam int max_cycles = n_tests * 200;

    localparam int k_ic   = 0;
    localparam int k_dc   = 1;
    localparam int k_wb   = 2;
    localparam int k_both = 3; // both refills in one cycle

    // kind, line address, fill base (writeback words are base + index)
    int    kind_tab [n_tests] = '{k_ic, k_dc, k_wb, k_both, k_ic, k_wb, k_both, k_dc};
    addr_t addr_tab [n_tests] = '{32'h0000_1000, 32'h0000_2040, 32'h0000_3080, 32'h0000_4000,
                                  32'h0001_00c0, 32'h0002_0100, 32'h0003_0200, 32'h0004_0020};
    word_t base_tab [n_tests] = '{32'h0, 32'h0, 32'h1111_0000, 32'h0,
                                  32'h0, 32'ha5a5_0010, 32'h0, 32'h0};

    logic                 clk;
    logic                 arst_n;
    logic                 ic_rd_req;
    addr_t                ic_rd_addr;
    logic                 ic_ret_valid;
    word_t [ic_lw-1:0]    ic_ret_line;
    logic                 dc_rd_req;
    addr_t                dc_rd_addr;
    logic                 dc_ret_valid;
    word_t [dc_lw-1:0]    dc_ret_line;
    logic                 dc_wr_req;
    addr_t                dc_wr_addr;
    word_t [dc_lw-1:0]    dc_wr_line;
    logic                 dc_wr_done;
    addr_t                m_axi_araddr;
    axi_len_t             m_axi_arlen;
    logic                 m_axi_arvalid;
    logic                 m_axi_arready = 1'b0;
    word_t                m_axi_rdata = '0;
    logic                 m_axi_rlast = 1'b0;
    logic                 m_axi_rvalid = 1'b0;
    logic                 m_axi_rready;
    addr_t                m_axi_awaddr;
    axi_len_t             m_axi_awlen;
    logic                 m_axi_awvalid;
    logic                 m_axi_awready = 1'b0;
    word_t                m_axi_wdata;
    logic                 m_axi_wlast;
    logic                 m_axi_wvalid;
    logic                 m_axi_wready = 1'b0;
    logic                 m_axi_bvalid = 1'b0;
    logic                 m_axi_bready;

    integer seed = 32'hd410;
    int     cycles = 0;
    logic   rd_busy = 1'b0;
    addr_t  rd_ptr;
    int     rd_left = 0;  // beats left after the present one
    logic   w_open = 1'b0;
    logic   b_pend = 1'b0;
    logic   b_fired_last = 1'b0;

    addr_t    ar_addr_q [$];
    axi_len_t ar_len_q [$];
    addr_t    aw_addr_q [$];
    axi_len_t aw_len_q [$];
    word_t    wdata_q [$];
    logic     wlast_q [$];

    tb_clock_gen u_clk_gen (
        .clk (clk)
    );

    axi_cache_bridge #(
        .icache_line_words (ic_lw),
        .dcache_line_words (dc_lw)
    ) dut (.*);

    function automatic word_t mem_word(addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic logic random_go();
        return ($random(seed) & 3) != 0; // stall about one cycle in four
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // read side of the slave memory, one burst at a time
    always @(posedge clk) begin : read_slave
        logic  busy_n;
        addr_t ptr_n;
        int    left_n;
        busy_n = rd_busy;
        ptr_n  = rd_ptr;
        left_n = rd_left;
        if (!arst_n) begin
            busy_n = 1'b0;
        end else begin
            if (m_axi_rvalid && m_axi_rready) begin
                busy_n = !m_axi_rlast;
                ptr_n  = rd_ptr + 32'd4;
                left_n = rd_left - 1;
            end
            if (m_axi_arvalid && m_axi_arready) begin
                busy_n = 1'b1;
                ptr_n  = m_axi_araddr;
                left_n = int'(m_axi_arlen);
                ar_addr_q.push_back(m_axi_araddr);
                ar_len_q.push_back(m_axi_arlen);
            end
        end
        rd_busy       <= busy_n;
        rd_ptr        <= ptr_n;
        rd_left       <= left_n;
        m_axi_arready <= !busy_n && random_go();
        m_axi_rvalid  <= busy_n && ((m_axi_rvalid && !m_axi_rready) || random_go());
        m_axi_rdata   <= mem_word(ptr_n);
        m_axi_rlast   <= busy_n && (left_n == 0);
    end

    // write side, records every beat for the checks
    always @(posedge clk) begin : write_slave
        logic open_n;
        logic pend_n;
        logic b_fire;
        open_n = w_open;
        pend_n = b_pend;
        b_fire = m_axi_bvalid && m_axi_bready;
        if (!arst_n) begin
            open_n = 1'b0;
            pend_n = 1'b0;
            b_fire = 1'b0;
        end else begin
            if (m_axi_awvalid && m_axi_awready) begin
                open_n = 1'b1;
                aw_addr_q.push_back(m_axi_awaddr);
                aw_len_q.push_back(m_axi_awlen);
            end
            if (m_axi_wvalid && m_axi_wready) begin
                wdata_q.push_back(m_axi_wdata);
                wlast_q.push_back(m_axi_wlast);
                if (m_axi_wlast) begin
                    open_n = 1'b0;
                    pend_n = 1'b1;
                end
            end
            if (b_fire) begin
                pend_n = 1'b0;
            end
        end
        w_open        <= open_n;
        b_pend        <= pend_n;
        b_fired_last  <= b_fire;
        m_axi_awready <= !open_n && !pend_n && random_go();
        m_axi_wready  <= random_go();
        m_axi_bvalid  <= pend_n && ((m_axi_bvalid && !m_axi_bready) || random_go());
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        word_t [dc_lw-1:0] fill;
        word_t [ic_lw-1:0] ic_got;
        word_t [dc_lw-1:0] dc_got;
        addr_t             ia;
        addr_t             da;
        logic              has_i;
        logic              has_d;
        logic              has_w;
        logic              need_i;
        logic              need_d;
        logic              need_w;
        int                n_ar;
        arst_n     <= 1'b0;
        ic_rd_req  <= 1'b0;
        ic_rd_addr <= '0;
        dc_rd_req  <= 1'b0;
        dc_rd_addr <= '0;
        dc_wr_req  <= 1'b0;
        dc_wr_addr <= '0;
        dc_wr_line <= '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        // ret_valid x2, wr_done, arvalid, rready, awvalid, wvalid, wlast, bready
        check_val("idle control outputs", 32'h0,
                  32'({ic_ret_valid, dc_ret_valid, dc_wr_done,
                       m_axi_arvalid, m_axi_rready, m_axi_awvalid,
                       m_axi_wvalid, m_axi_wlast, m_axi_bready}));

        for (int i = 0; i < n_tests; i++) begin
            has_i = (kind_tab[i] == k_ic) || (kind_tab[i] == k_both);
            has_d = (kind_tab[i] == k_dc) || (kind_tab[i] == k_both);
            has_w = (kind_tab[i] == k_wb);
            da    = addr_tab[i];
            ia    = (kind_tab[i] == k_both) ? (addr_tab[i] ^ 32'h0001_0000) : addr_tab[i];
            for (int k = 0; k < dc_lw; k++) begin
                fill[k] = base_tab[i] + 32'(k);
            end
            ar_addr_q.delete();
            ar_len_q.delete();
            aw_addr_q.delete();
            aw_len_q.delete();
            wdata_q.delete();
            wlast_q.delete();

            @(posedge clk);
            ic_rd_req  <= has_i;
            ic_rd_addr <= ia;
            dc_rd_req  <= has_d;
            dc_rd_addr <= da;
            dc_wr_req  <= has_w;
            dc_wr_addr <= da;
            dc_wr_line <= fill;
            @(posedge clk);
            ic_rd_req <= 1'b0;
            dc_rd_req <= 1'b0;
            dc_wr_req <= 1'b0;

            need_i = has_i;
            need_d = has_d;
            need_w = has_w;
            while (need_i || need_d || need_w) begin
                @(posedge clk);
                if (need_i && ic_ret_valid) begin
                    ic_got = ic_ret_line;
                    need_i = 1'b0;
                end
                if (need_d && dc_ret_valid) begin
                    dc_got = dc_ret_line;
                    need_d = 1'b0;
                end
                if (need_w && dc_wr_done) begin
                    check_val($sformatf("entry %0d wr_done after bresp", i), 32'h1,
                              32'(b_fired_last));
                    need_w = 1'b0;
                end
            end

            check_val($sformatf("entry %0d read bursts", i), 32'(has_i) + 32'(has_d),
                      32'(ar_addr_q.size()));
            n_ar = 0;
            if (has_d) begin  // dcache wins the first grant
                check_val($sformatf("entry %0d dcache araddr", i), da, ar_addr_q[n_ar]);
                check_val($sformatf("entry %0d dcache arlen", i), 32'(dc_lw - 1),
                          32'(ar_len_q[n_ar]));
                n_ar++;
                for (int k = 0; k < dc_lw; k++) begin
                    check_val($sformatf("entry %0d dcache word %0d", i, k),
                              mem_word(da + 32'(4 * k)), dc_got[k]);
                end
            end
            if (has_i) begin
                check_val($sformatf("entry %0d icache araddr", i), ia, ar_addr_q[n_ar]);
                check_val($sformatf("entry %0d icache arlen", i), 32'(ic_lw - 1),
                          32'(ar_len_q[n_ar]));
                for (int k = 0; k < ic_lw; k++) begin
                    check_val($sformatf("entry %0d icache word %0d", i, k),
                              mem_word(ia + 32'(4 * k)), ic_got[k]);
                end
            end

            check_val($sformatf("entry %0d write bursts", i), 32'(has_w),
                      32'(aw_addr_q.size()));
            check_val($sformatf("entry %0d write beats", i), has_w ? 32'(dc_lw) : 32'h0,
                      32'(wdata_q.size()));
            if (has_w) begin
                check_val($sformatf("entry %0d awaddr", i), da, aw_addr_q[0]);
                check_val($sformatf("entry %0d awlen", i), 32'(dc_lw - 1), 32'(aw_len_q[0]));
                for (int k = 0; k < dc_lw; k++) begin
                    check_val($sformatf("entry %0d wdata %0d", i, k),
                              base_tab[i] + 32'(k), wdata_q[k]);
                    check_val($sformatf("entry %0d wlast %0d", i, k),
                              32'(k == dc_lw - 1), 32'(wlast_q[k]));
                end
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- sim.f
cache_axi_pkg.sv
axi_rd_if.sv
line_refill.sv
line_writeback.sv
read_arbiter.sv
axi_cache_bridge.sv
tb_clock_gen.sv
axi_cache_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module axi_cache_bridge_tb -f sim.f

out=$(./obj_dir/Vaxi_cache_bridge_tb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
